/* verilog/fwht_macros.svh */
/* Build-time packet size and widths for the in-place FWHT.
   FWHT_ACC_W covers input width plus log2 growth up to 64 points. */

`ifndef FWHT_MACROS_SVH
`define FWHT_MACROS_SVH

// Log2 of points per packet
`define FWHT_LOG2N 4

// Points per packet, always a power of two
`define FWHT_POINTS (1 << `FWHT_LOG2N)

// Input component width, signed
`define FWHT_IN_W 18

// Internal and output component width, signed
`define FWHT_ACC_W 24

`endif

/* verilog/fwht_pkg.sv */
/* Shared types for the FWHT memory subsystem.
   Widths follow the build-time macros. */

package fwht_pkg;

`include "fwht_macros.svh"

	// Component types
	typedef logic signed [`FWHT_IN_W-1:0]  in_t;
	typedef logic signed [`FWHT_ACC_W-1:0] acc_t;

	// Point address and bank row (address minus its lowest bit)
	typedef logic [`FWHT_LOG2N-1:0] addr_t;
	typedef logic [`FWHT_LOG2N-2:0] row_t;

	// Complex sample in accumulator width
	typedef struct packed {
		acc_t re;
		acc_t im;
	} sample_t;

	// Input beat, plain strobes
	typedef struct packed {
		logic valid;
		logic sop;
		in_t  re;
		in_t  im;
	} in_beat_t;

	// Output beat
	typedef struct packed {
		logic    valid;
		logic    sop;
		logic    eop;
		sample_t data;
	} out_beat_t;

	// Bank write port
	typedef struct packed {
		logic    en;
		row_t    row;
		sample_t data;
	} bank_wr_t;

	// Bank read port, data returns one cycle later
	typedef struct packed {
		logic en;
		row_t row;
	} bank_rd_t;

	// Top sequencing
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SINK,
		ST_XFORM,
		ST_SOURCE
	} fwht_state_t;

endpackage

/* verilog/fwht_bank.sv */
/* Half-packet RAM bank, one write and one registered read port.
   Read and write of the same row in one cycle returns the old data. */

`timescale 1ns/100ps

`include "fwht_macros.svh"

module fwht_bank
	import fwht_pkg::*;
(
	input  logic     clk,
	input  bank_wr_t wr,
	input  bank_rd_t rd,
	output sample_t  rd_data
);

	// One row per address pair
	sample_t mem [`FWHT_POINTS/2];

	// Write port
	always_ff @(posedge clk)
	begin
		if (wr.en)
		begin
			mem[wr.row] <= wr.data;
		end
	end

	// Registered read, data valid the cycle after en
	always_ff @(posedge clk)
	begin
		if (rd.en)
		begin
			rd_data <= mem[rd.row];
		end
	end

endmodule

/* verilog/fwht_sink.sv */
/* Writes one packet of FWHT_POINTS valid beats into the two banks.
   Counter restarts whenever active drops. */

`timescale 1ns/100ps

`include "fwht_macros.svh"

module fwht_sink
	import fwht_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     active,
	input  in_beat_t in_beat,
	output bank_wr_t wr0,
	output bank_wr_t wr1,
	output logic     sink_done
);

	addr_t   cnt;
	logic    running;
	logic    accept;
	logic    bank;
	logic    wr_en0;
	logic    wr_en1;
	row_t    wr_row;
	sample_t wr_data;

	// Sop opens the packet, later beats need only valid
	assign accept = active && in_beat.valid && (running || in_beat.sop);

	// Bank by address parity
	assign bank = ^cnt;

	always_ff @(posedge clk)
	begin
		if (!rst_n || !active)
		begin
			cnt       <= '0;
			running   <= 1'b0;
			wr_en0    <= 1'b0;
			wr_en1    <= 1'b0;
			sink_done <= 1'b0;
		end
		else
		begin
			wr_en0    <= accept && !bank;
			wr_en1    <= accept && bank;
			sink_done <= accept && (cnt == addr_t'(`FWHT_POINTS-1));
			if (accept)
			begin
				cnt     <= (cnt == addr_t'(`FWHT_POINTS-1)) ? '0 : cnt + 1'b1;
				running <= (cnt != addr_t'(`FWHT_POINTS-1));
			end
		end
	end

	// Payload, sign-extended to accumulator width
	always_ff @(posedge clk)
	begin
		wr_row     <= row_t'(cnt >> 1);
		wr_data.re <= acc_t'(in_beat.re);
		wr_data.im <= acc_t'(in_beat.im);
	end

	assign wr0 = '{en: wr_en0, row: wr_row, data: wr_data};
	assign wr1 = '{en: wr_en1, row: wr_row, data: wr_data};

endmodule

/* verilog/fwht_butterfly.sv */
/* In-place radix-2 stage loop with unit twiddles (Walsh-Hadamard).
   Pair a/b always sits in opposite banks; three pairs in flight. */

`timescale 1ns/100ps

`include "fwht_macros.svh"

module fwht_butterfly
	import fwht_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     start,
	output bank_rd_t rd0,
	output bank_rd_t rd1,
	input  sample_t  rd_data0,
	input  sample_t  rd_data1,
	output bank_wr_t wr0,
	output bank_wr_t wr1,
	output logic     xform_done
);

	localparam int STAGE_W = $clog2(`FWHT_LOG2N);

	// Address with bit v inserted at position s
	function automatic addr_t insert_bit(input row_t p, input logic [STAGE_W-1:0] s,
		input logic v);
		addr_t low_mask;
		addr_t hi_mask;
		low_mask = (addr_t'(1) << s) - addr_t'(1);
		hi_mask  = ~(low_mask | (addr_t'(1) << s));
		return ((addr_t'(p) << 1) & hi_mask) | (addr_t'(p) & low_mask) |
			(addr_t'(v) << s);
	endfunction

	logic               reading;
	logic               draining;
	row_t               pair_cnt;
	logic [STAGE_W-1:0] stage_cnt;
	logic [1:0]         drain_cnt;
	addr_t              addr_a;
	addr_t              addr_b;
	logic               swap;

	// Pipeline, stage 1 follows the read, stage 2 holds results
	logic    vld1, vld2;
	row_t    row_a1, row_b1, row_a2, row_b2;
	logic    swap1, swap2;
	sample_t x, y;
	sample_t sum2, diff2;

	// ------------------------------------------------------------------
	// Stage and pair sequencing
	// ------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			reading    <= 1'b0;
			draining   <= 1'b0;
			pair_cnt   <= '0;
			stage_cnt  <= '0;
			drain_cnt  <= '0;
			xform_done <= 1'b0;
		end
		else
		begin
			xform_done <= 1'b0;
			if (start)
			begin
				reading   <= 1'b1;
				pair_cnt  <= '0;
				stage_cnt <= '0;
			end
			else if (reading)
			begin
				pair_cnt <= pair_cnt + 1'b1;
				if (pair_cnt == row_t'(`FWHT_POINTS/2-1))
				begin
					reading   <= 1'b0;
					draining  <= 1'b1;
					drain_cnt <= '0;
				end
			end
			else if (draining)
			begin
				// Three cycles so the last write lands first
				drain_cnt <= drain_cnt + 1'b1;
				if (drain_cnt == 2'd2)
				begin
					draining <= 1'b0;
					if (stage_cnt == STAGE_W'(`FWHT_LOG2N-1))
					begin
						xform_done <= 1'b1;
					end
					else
					begin
						stage_cnt <= stage_cnt + 1'b1;
						reading   <= 1'b1;
						pair_cnt  <= '0;
					end
				end
			end
		end
	end

	// Pair addresses, a has bit s clear
	assign addr_a = insert_bit(pair_cnt, stage_cnt, 1'b0);
	assign addr_b = insert_bit(pair_cnt, stage_cnt, 1'b1);
	assign swap   = ^addr_a;

	// Reads go to both banks every cycle of a stage
	assign rd0 = '{en: reading, row: swap ? row_t'(addr_b >> 1) : row_t'(addr_a >> 1)};
	assign rd1 = '{en: reading, row: swap ? row_t'(addr_a >> 1) : row_t'(addr_b >> 1)};

	// ------------------------------------------------------------------
	// Add/subtract pipeline
	// ------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			vld1 <= 1'b0;
			vld2 <= 1'b0;
		end
		else
		begin
			vld1 <= reading;
			vld2 <= vld1;
		end
	end

	// Undo the parity swap on read data
	assign x = swap1 ? rd_data1 : rd_data0;
	assign y = swap1 ? rd_data0 : rd_data1;

	always_ff @(posedge clk)
	begin
		row_a1   <= row_t'(addr_a >> 1);
		row_b1   <= row_t'(addr_b >> 1);
		swap1    <= swap;
		row_a2   <= row_a1;
		row_b2   <= row_b1;
		swap2    <= swap1;
		sum2.re  <= x.re + y.re;
		sum2.im  <= x.im + y.im;
		diff2.re <= x.re - y.re;
		diff2.im <= x.im - y.im;
	end

	// Sum back to a, difference back to b, each in its own bank
	assign wr0 = swap2 ? '{en: vld2, row: row_b2, data: diff2}
		: '{en: vld2, row: row_a2, data: sum2};
	assign wr1 = swap2 ? '{en: vld2, row: row_a2, data: sum2}
		: '{en: vld2, row: row_b2, data: diff2};

endmodule

/* verilog/fwht_source.sv */
/* Natural-order readout, one address per cycle after start.
   Flags and bank select line up with bank read data. */

`timescale 1ns/100ps

`include "fwht_macros.svh"

module fwht_source
	import fwht_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     start,
	output bank_rd_t rd0,
	output bank_rd_t rd1,
	output logic     bank_sel,
	output logic     first,
	output logic     last,
	output logic     source_done
);

	addr_t addr;
	logic  running;
	logic  bank;
	logic  at_end;

	assign bank   = ^addr;
	assign at_end = (addr == addr_t'(`FWHT_POINTS-1));

	// Address walk
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			running <= 1'b0;
			addr    <= '0;
		end
		else if (start)
		begin
			running <= 1'b1;
			addr    <= '0;
		end
		else if (running)
		begin
			addr <= addr + 1'b1;
			if (at_end)
			begin
				running <= 1'b0;
			end
		end
	end

	// Only the bank holding this address reads
	assign rd0 = '{en: running && !bank, row: row_t'(addr >> 1)};
	assign rd1 = '{en: running && bank, row: row_t'(addr >> 1)};

	// One cycle delay to match read data
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			bank_sel    <= 1'b0;
			first       <= 1'b0;
			last        <= 1'b0;
			source_done <= 1'b0;
		end
		else
		begin
			bank_sel    <= bank;
			first       <= running && (addr == '0);
			last        <= running && at_end;
			source_done <= last; // Lines up with out_beat eop in the top
		end
	end

endmodule

/* verilog/fwht_mem_top.sv */
/* In-place FWHT memory top: sink, stage loop, source, one packet at a time.
   No back-pressure; input beats outside idle/sink are dropped. */

`timescale 1ns/100ps

module fwht_mem_top
	import fwht_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  in_beat_t  in_beat,
	output out_beat_t out_beat,
	output logic      busy
);

	fwht_state_t state, state_q;

	bank_wr_t bank_wr   [2];
	bank_rd_t bank_rd   [2];
	sample_t  bank_data [2];

	bank_wr_t snk_wr0, snk_wr1;
	bank_wr_t bf_wr0, bf_wr1;
	bank_rd_t bf_rd0, bf_rd1;
	bank_rd_t src_rd0, src_rd1;
	logic     sink_done, xform_done, source_done;
	logic     start_xform, start_source;
	logic     src_bank_sel, src_first, src_last;
	logic     rd_any_q;
	logic     out_valid, out_sop, out_eop;
	sample_t  out_data;

	// ------------------------------------------------------------------
	// Sequencing FSM
	// ------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state   <= ST_IDLE;
			state_q <= ST_IDLE;
		end
		else
		begin
			state_q <= state;
			case (state)
				ST_IDLE:   if (in_beat.valid && in_beat.sop) state <= ST_SINK;
				ST_SINK:   if (sink_done) state <= ST_XFORM;
				ST_XFORM:  if (xform_done) state <= ST_SOURCE;
				ST_SOURCE: if (source_done) state <= ST_IDLE;
				default:   state <= ST_IDLE;
			endcase
		end
	end

	// Start pulses on state entry
	assign start_xform  = (state == ST_XFORM) && (state_q != ST_XFORM);
	assign start_source = (state == ST_SOURCE) && (state_q != ST_SOURCE);

	assign busy = (state != ST_IDLE);

	// ------------------------------------------------------------------
	// Bank port switching
	// ------------------------------------------------------------------
	always_comb
	begin
		bank_wr[0] = '0;
		bank_wr[1] = '0;
		bank_rd[0] = '0;
		bank_rd[1] = '0;
		case (state)
			ST_SINK:
			begin
				bank_wr[0] = snk_wr0;
				bank_wr[1] = snk_wr1;
			end
			ST_XFORM:
			begin
				bank_wr[0] = bf_wr0;
				bank_wr[1] = bf_wr1;
				bank_rd[0] = bf_rd0;
				bank_rd[1] = bf_rd1;
			end
			ST_SOURCE:
			begin
				bank_rd[0] = src_rd0;
				bank_rd[1] = src_rd1;
			end
			default: ;
		endcase
	end

	for (genvar i = 0; i < 2; i++)
	begin : g_bank
		fwht_bank u_bank (
			.clk     (clk),
			.wr      (bank_wr[i]),
			.rd      (bank_rd[i]),
			.rd_data (bank_data[i])
		);
	end

	fwht_sink u_sink (
		.clk       (clk),
		.rst_n     (rst_n),
		.active    ((state == ST_IDLE) || (state == ST_SINK)),
		.in_beat   (in_beat),
		.wr0       (snk_wr0),
		.wr1       (snk_wr1),
		.sink_done (sink_done)
	);

	fwht_butterfly u_butterfly (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (start_xform),
		.rd0        (bf_rd0),
		.rd1        (bf_rd1),
		.rd_data0   (bank_data[0]),
		.rd_data1   (bank_data[1]),
		.wr0        (bf_wr0),
		.wr1        (bf_wr1),
		.xform_done (xform_done)
	);

	fwht_source u_source (
		.clk         (clk),
		.rst_n       (rst_n),
		.start       (start_source),
		.rd0         (src_rd0),
		.rd1         (src_rd1),
		.bank_sel    (src_bank_sel),
		.first       (src_first),
		.last        (src_last),
		.source_done (source_done)
	);

	// ------------------------------------------------------------------
	// Output register, two cycles after the source read
	// ------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			rd_any_q  <= 1'b0;
			out_valid <= 1'b0;
			out_sop   <= 1'b0;
			out_eop   <= 1'b0;
		end
		else
		begin
			rd_any_q  <= src_rd0.en || src_rd1.en;
			out_valid <= rd_any_q;
			out_sop   <= src_first;
			out_eop   <= src_last;
		end
	end

	always_ff @(posedge clk)
	begin
		out_data <= src_bank_sel ? bank_data[1] : bank_data[0];
	end

	assign out_beat = '{valid: out_valid, sop: out_sop, eop: out_eop, data: out_data};

endmodule

/* testbench/fwht_tb.sv */
/* Self-checking testbench for fwht_mem_top, one packet in flight at a time.
   Expected data is a direct Walsh-Hadamard sum per component. */

`timescale 1ns/100ps

`include "fwht_macros.svh"

module fwht_tb
	import fwht_pkg::*;
();

	localparam int N          = `FWHT_POINTS;
	localparam int NUM_PKTS   = 14;
	// Sink, stage loop, readout and drain, plus worst-case input gaps
	localparam int PKT_CYCLES = 2 * N + `FWHT_LOG2N * (N / 2 + 3) + 16 + 3 * N;
	localparam int MAX_CYCLES = NUM_PKTS * PKT_CYCLES + 1000;

	logic      clk;
	logic      rst_n;
	in_beat_t  in_beat;
	out_beat_t out_beat;
	logic      busy;

	int     seed;
	int     cycles;
	int     errors;
	int     tests_run;
	int     tests_failed;
	string  test_name;
	int     beat_idx;
	bit     in_pkt;
	bit     pkt_done;
	longint in_re [N];
	longint in_im [N];
	longint exp_re [N];
	longint exp_im [N];
	longint got_re [N];
	longint got_im [N];
	longint saved_re [N];
	longint saved_im [N];

	fwht_mem_top DUT (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_beat  (in_beat),
		.out_beat (out_beat),
		.busy     (busy)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Run limit
	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES)
		begin
			$display("timeout after %0d cycles, output packet never completed", cycles);
			$display("test failed");
			$finish;
		end
	end

	// ------------------------------------------------------------------
	// Reference and checking helpers
	// ------------------------------------------------------------------

	// out[k] = sum of x[n] * (-1)^popcount(k & n)
	function automatic longint wht_ref(input int k, input longint x [N]);
		longint acc;
		int     n;
		acc = 0;
		for (n = 0; n < N; n++)
		begin
			if ($countones(k & n) % 2 == 1)
				acc = acc - x[n];
			else
				acc = acc + x[n];
		end
		return acc;
	endfunction

	task automatic check_value(input string name, input longint expected,
		input longint actual);
		if (expected != actual)
		begin
			$display("FAIL %s: expected %0d, actual %0d", name, expected, actual);
			errors++;
		end
	endtask

	task automatic report_error(input string msg);
		$display("ERROR %s: %s", test_name, msg);
		errors++;
	endtask

	// Full-scale 18-bit components
	task automatic load_random();
		int  i;
		int  rnd;
		in_t part;
		for (i = 0; i < N; i++)
		begin
			rnd       = $random(seed);
			part      = in_t'(rnd);
			in_re[i]  = part;
			rnd       = $random(seed);
			part      = in_t'(rnd);
			in_im[i]  = part;
		end
	endtask

	// ------------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------------
	task automatic drive_packet(input bit gaps);
		int i;
		int gap;
		for (i = 0; i < N; i++)
		begin
			// Idle cycles with valid low between beats
			if (gaps && i > 0)
			begin
				gap = $random(seed) & 3;
				repeat (gap)
				begin
					@(posedge clk);
					in_beat <= '0;
				end
			end
			@(posedge clk);
			in_beat <= '{valid: 1'b1, sop: (i == 0), re: in_t'(in_re[i]), im: in_t'(in_im[i])};
		end
		@(posedge clk);
		in_beat <= '0;
	endtask

	// Stray sop beats while the stage loop runs
	task automatic inject_sop_beats();
		int j;
		repeat (4) @(posedge clk);
		@(negedge clk);
		check_value($sformatf("%s busy at injection", test_name), 1, busy);
		for (j = 0; j < 3; j++)
		begin
			@(posedge clk);
			in_beat <= '{valid: 1'b1, sop: 1'b1, re: in_t'(j * 1000 + 5), im: in_t'(-j - 9)};
		end
		@(posedge clk);
		in_beat <= '0;
	endtask

	task automatic run_test(input string name, input bit gaps, input bit inject,
		input bit vs_saved);
		int k;
		int errors_before;
		errors_before = errors;
		test_name     = name;
		for (k = 0; k < N; k++)
		begin
			exp_re[k] = wht_ref(k, in_re);
			exp_im[k] = wht_ref(k, in_im);
		end
		beat_idx = 0;
		in_pkt   = 1'b0;
		pkt_done = 1'b0;
		drive_packet(gaps);
		if (inject)
			inject_sop_beats();
		while (!pkt_done)
			@(negedge clk);
		while (busy)
			@(negedge clk);
		if (vs_saved)
		begin
			for (k = 0; k < N; k++)
			begin
				check_value($sformatf("%s vs no_gaps re[%0d]", name, k), saved_re[k], got_re[k]);
				check_value($sformatf("%s vs no_gaps im[%0d]", name, k), saved_im[k], got_im[k]);
			end
		end
		tests_run++;
		if (errors == errors_before)
			$display("%-16s ok", name);
		else
		begin
			tests_failed++;
			$display("%-16s %0d error(s)", name, errors - errors_before);
		end
	endtask

	// ------------------------------------------------------------------
	// Output collection and compare, sampled mid-cycle
	// ------------------------------------------------------------------
	always @(negedge clk)
	begin
		if (rst_n && out_beat.valid)
		begin
			if (beat_idx == 0 && !out_beat.sop)
				report_error("first output beat has no sop");
			if (beat_idx != 0 && out_beat.sop)
				report_error($sformatf("sop on output beat %0d", beat_idx));
			if (beat_idx < N)
			begin
				got_re[beat_idx] = out_beat.data.re;
				got_im[beat_idx] = out_beat.data.im;
				check_value($sformatf("%s re[%0d]", test_name, beat_idx), exp_re[beat_idx],
					got_re[beat_idx]);
				check_value($sformatf("%s im[%0d]", test_name, beat_idx), exp_im[beat_idx],
					got_im[beat_idx]);
			end
			beat_idx++;
			in_pkt = 1'b1;
			if (out_beat.eop)
			begin
				if (beat_idx != N)
					report_error($sformatf("eop after %0d beats instead of %0d", beat_idx, N));
				in_pkt   = 1'b0;
				pkt_done = 1'b1;
			end
			else if (beat_idx == N)
			begin
				report_error("last output beat has no eop");
				in_pkt   = 1'b0;
				pkt_done = 1'b1;
			end
		end
		else if (rst_n && in_pkt)
		begin
			report_error($sformatf("output valid dropped after %0d beats", beat_idx));
			in_pkt   = 1'b0;
			pkt_done = 1'b1;
		end
	end

	// ------------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------------
	initial
	begin
		int i;
		int t;
		seed         = 32'h1637326a;
		cycles       = 0;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		beat_idx     = 0;
		in_pkt       = 1'b0;
		pkt_done     = 1'b0;
		test_name    = "reset";
		rst_n        = 1'b0;
		in_beat      = '0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_value("reset busy", 0, busy);
		check_value("reset out valid", 0, out_beat.valid);
		repeat (3) @(negedge clk);
		check_value("idle busy before first packet", 0, busy);

		// Impulse at address 0
		for (i = 0; i < N; i++)
		begin
			in_re[i] = 0;
			in_im[i] = 0;
		end
		in_re[0] = 1000;
		in_im[0] = -777;
		run_test("impulse", 1'b0, 1'b0, 1'b0);

		// Constant at full scale, growth to 22 bits
		for (i = 0; i < N; i++)
		begin
			in_re[i] = -131072;
			in_im[i] = 131071;
		end
		run_test("constant", 1'b0, 1'b0, 1'b0);

		for (t = 0; t < 8; t++)
		begin
			load_random();
			run_test($sformatf("random_%0d", t), 1'b0, 1'b0, 1'b0);
		end

		// Same data with and without input gaps
		load_random();
		run_test("no_gaps", 1'b0, 1'b0, 1'b0);
		saved_re = got_re;
		saved_im = got_im;
		run_test("with_gaps", 1'b1, 1'b0, 1'b1);

		// Stray sop while busy, then a clean packet
		load_random();
		run_test("sop_while_busy", 1'b0, 1'b1, 1'b0);
		load_random();
		run_test("after_busy", 1'b0, 1'b0, 1'b0);

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

/* list.f */
+incdir+verilog
verilog/fwht_pkg.sv
verilog/fwht_bank.sv
verilog/fwht_sink.sv
verilog/fwht_butterfly.sv
verilog/fwht_source.sv
verilog/fwht_mem_top.sv
testbench/fwht_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile the FWHT testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -f list.f --top-module fwht_tb -o fwht_sim \
	&& ./obj_dir/fwht_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "test failed" sim.log && exit 1
grep -q "test passed" sim.log || exit 1
exit 0
